// File: cart_header_regs.sv
`timescale 1ns/100ps

module cart_header_regs import gb_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,	// cartridge image download in progress
	input  logic        dl_wr,		// one-cycle write strobe
	input  logic [24:0] dl_addr,	// byte address of the even byte
	input  logic [15:0] dl_data,	// odd byte in [15:8]
	output logic [2:0]  mbc_kind,
	output logic [8:0]  rom_mask,
	output logic [3:0]  ram_mask,
	output logic        cart_ready
);

	logic [7:0] type_byte;	// 0x147
	logic [7:0] rom_size;	// 0x148
	logic [7:0] ram_size;	// 0x149
	logic       hdr_wr;

	assign hdr_wr = dl_active & dl_wr;

	// --------------------------------------------------
	// header capture
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte  <= 8'h00;	// reads as no mapper
			rom_size   <= 8'h00;
			ram_size   <= 8'h00;
			cart_ready <= 1'b0;
		end else begin
			if (hdr_wr)
				cart_ready <= 1'b1;	// any download write means an image exists
			if (hdr_wr && dl_addr == HDR_TYPE_OFS)
				type_byte <= dl_data[15:8];
			if (hdr_wr && dl_addr == HDR_SIZE_OFS) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// mapper kind from the cart type byte
	always_comb begin
		if (type_byte inside {[8'h01:8'h03]})
			mbc_kind = MBC_1;
		else if (type_byte inside {[8'h05:8'h06]})
			mbc_kind = MBC_2;
		else if (type_byte inside {[8'h0F:8'h13]})
			mbc_kind = MBC_3;
		else if (type_byte inside {[8'h19:8'h1E]})
			mbc_kind = MBC_5;
		else
			mbc_kind = MBC_NONE;	// plain rom and unsupported mappers
	end

	// size n means 2^(n+1) banks of 16k, odd sizes fall back to 128 banks
	always_comb begin
		if (rom_size <= 8'd8)
			rom_mask = 9'h1FF >> (4'd8 - rom_size[3:0]);
		else
			rom_mask = 9'h07F;
	end

	always_comb begin
		case (ram_size)
			8'd0, 8'd1, 8'd2: ram_mask = 4'h0;	// none, 2k or a single 8k bank
			8'd3:             ram_mask = 4'h3;	// 32k in four banks
			default:          ram_mask = 4'hF;	// 128k in sixteen banks
		endcase
	end

endmodule

// File: cram_lane.sv
`timescale 1ns/100ps

module cram_lane #(
	parameter int LANE_ADDR_BITS = 16
) (
	input  logic                      clk_sys,
	input  logic [LANE_ADDR_BITS-1:0] addr,
	input  logic                      we,
	input  logic [7:0]                wdata,
	output logic [7:0]                q		// one cycle behind addr
);

	// one byte lane of cart ram, contents kept across reset
	logic [7:0] mem [2**LANE_ADDR_BITS];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= wdata;
		q <= mem[addr];	// old data on a write cycle
	end

endmodule

// File: cram_lane_ctrl.sv
`timescale 1ns/100ps

module cram_lane_ctrl import gb_cart_pkg::*; #(
	parameter int LANE_ADDR_BITS = 16	// words per lane as a power of two
) (
	input  cart_addr_t                cart_addr,
	input  logic                      cart_wr,
	input  logic [3:0]                ram_bank,	// masked bank from the registers
	input  logic [2:0]                mbc_kind,
	output logic [LANE_ADDR_BITS-1:0] lane_addr,
	output logic [1:0]                lane_we,		// bit 0 even bytes, bit 1 odd bytes
	output logic                      lane_sel
);

	logic        banked;		// mapper with switchable ram
	logic [16:0] byte_addr;	// 16 banks of 8k
	logic        cram_wr;

	// --------------------------------------------------
	// banked byte address
	// --------------------------------------------------
	assign banked = (mbc_kind == MBC_1) || (mbc_kind == MBC_3) || (mbc_kind == MBC_5);

	assign byte_addr = {(banked ? ram_bank : 4'd0), cart_addr.ctl.sub};

	// two byte lanes share one word address
	assign lane_addr = byte_addr[LANE_ADDR_BITS:1];	// bank bits above the lane drop off
	assign lane_sel  = byte_addr[0];

	// writes land in the lane picked by address bit 0
	assign cram_wr = cart_wr && (cart_addr.ctl.sel == SEL_CRAM);
	assign lane_we = {cram_wr & lane_sel, cram_wr & ~lane_sel};

endmodule

// File: cram_read_mux.sv
`timescale 1ns/100ps

module cram_read_mux import gb_cart_pkg::*; (
	input  logic        clk_sys,
	input  cart_addr_t  cart_addr,
	input  logic        lane_sel,	// byte lane of the current address
	input  logic [7:0]  lane_q_lo,
	input  logic [7:0]  lane_q_hi,
	input  logic [15:0] rom_rdata,	// word for the current rom_addr
	input  logic        ram_enable,
	input  logic        rtc_mode,
	input  logic [2:0]  mbc_kind,
	input  logic        cart_ready,
	output logic [7:0]  cart_do
);

	logic       sel_q;		// lane_sel aligned with the lane read
	logic [7:0] lane_byte;
	logic       is_cram;
	logic       mbc2_window;	// 512 x 4 bit ram inside the mbc2 chip

	always_ff @(posedge clk_sys) begin
		sel_q <= lane_sel;
	end

	assign lane_byte   = sel_q ? lane_q_hi : lane_q_lo;
	assign is_cram     = (cart_addr.ctl.sel == SEL_CRAM);
	assign mbc2_window = (mbc_kind == MBC_2) && (cart_addr.ctl.sub[12:9] == 4'd0);

	// --------------------------------------------------
	// cpu read data
	// --------------------------------------------------
	always_comb begin
		if (!cart_ready)
			cart_do = 8'h00;	// nothing loaded yet
		else if (is_cram) begin
			if (!ram_enable)
				cart_do = 8'hFF;	// open bus
			else if (mbc2_window)
				cart_do = {4'hF, lane_byte[3:0]};	// only the low nibble exists
			else if (rtc_mode)
				cart_do = 8'h00;	// clock registers not modelled
			else
				cart_do = lane_byte;
		end else if (cart_addr.rom.offset[0])
			cart_do = rom_rdata[15:8];
		else
			cart_do = rom_rdata[7:0];
	end

endmodule

// File: gb_cart_pkg.sv
package gb_cart_pkg;

	// --------------------------------------------------
	// cpu address, decoded two ways
	// --------------------------------------------------

	// rom read view over the 0x0000-0x7fff space
	typedef struct packed {
		logic [1:0]  region;	// 16k window, 0 is fixed bank and 1 is switchable
		logic [13:0] offset;	// byte inside the 16k bank
	} rom_view_t;

	// register select view, one 8k slot per select value
	typedef struct packed {
		logic [2:0]  sel;	// which 8k slot was hit
		logic [12:0] sub;	// bit 12 picks mbc5 low or high rom bank
	} ctl_view_t;

	typedef union packed {
		rom_view_t rom;
		ctl_view_t ctl;
	} cart_addr_t;

	// decoded mapper kind
	localparam logic [2:0] MBC_NONE = 3'd0;
	localparam logic [2:0] MBC_1    = 3'd1;
	localparam logic [2:0] MBC_2    = 3'd2;
	localparam logic [2:0] MBC_3    = 3'd3;
	localparam logic [2:0] MBC_5    = 3'd4;

	// header word addresses, odd byte sits in the upper half of the word
	localparam logic [24:0] HDR_CGB_OFS  = 25'h142;	// cgb flag at 0x143
	localparam logic [24:0] HDR_TYPE_OFS = 25'h146;	// cart type at 0x147
	localparam logic [24:0] HDR_SIZE_OFS = 25'h148;	// rom size low, ram size high

	// 8k slot selects seen through the control view
	localparam logic [2:0] SEL_RAM_EN   = 3'b000;	// 0x0000-0x1fff
	localparam logic [2:0] SEL_ROM_BANK = 3'b001;	// 0x2000-0x3fff
	localparam logic [2:0] SEL_RAM_BANK = 3'b010;	// 0x4000-0x5fff
	localparam logic [2:0] SEL_MODE     = 3'b011;	// 0x6000-0x7fff
	localparam logic [2:0] SEL_CRAM     = 3'b101;	// 0xa000-0xbfff

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;	// low nibble that opens cart ram

endpackage

// File: gb_cart_props.sv
`timescale 1ns/100ps

module gb_cart_props import gb_cart_pkg::*; (
	input logic        clk_sys,
	input logic        reset,
	input cart_addr_t  cart_addr,
	input logic [2:0]  mbc_kind,
	input logic        cart_ready,
	input logic        ram_enable,
	input logic [22:0] rom_addr,
	input logic [7:0]  cart_do
);

	// nothing is driven out before an image arrives
	a_idle_zero: assert property (@(posedge clk_sys) !cart_ready |-> cart_do == 8'h00)
		else $error("cart_do not zero with no cartridge loaded");

	a_reset_ram_off: assert property (@(posedge clk_sys) $past(reset) |-> !ram_enable)
		else $error("ram_enable set right after reset");

	// fixed bank 0 below 0x4000, bank sits in rom_addr[21:13]
	a_bank0: assert property (@(posedge clk_sys) disable iff (reset)
		(mbc_kind != MBC_NONE && cart_addr.rom.region == 2'd0) |-> rom_addr[21:13] == 9'd0)
		else $error("region 0 read mapped outside bank 0");

endmodule

bind gb_cart_top gb_cart_props props_i (
	.clk_sys, .reset, .cart_addr, .mbc_kind, .cart_ready, .ram_enable, .rom_addr, .cart_do
);

// File: gb_cart_top.sv
`timescale 1ns/100ps

module gb_cart_top import gb_cart_pkg::*; #(
	parameter int LANE_ADDR_BITS = 16	// 16 holds the full 128k of cart ram
) (
	input  logic        clk_sys,
	input  logic        reset,
	// image download
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	// cpu side, reads are served every cycle so cart_rd needs no decode
	input  cart_addr_t  cart_addr,
	input  logic        cart_rd,
	input  logic        cart_wr,
	input  logic [7:0]  cart_di,
	// external rom
	input  logic [15:0] rom_rdata,
	output logic [22:0] rom_addr,
	output logic [7:0]  cart_do
);

	logic [2:0]                mbc_kind;
	logic [8:0]                rom_mask;
	logic [3:0]                ram_mask;
	logic                      cart_ready;
	logic [8:0]                rom_bank;
	logic [3:0]                ram_bank;
	logic                      ram_enable;
	logic                      rtc_mode;
	logic [LANE_ADDR_BITS-1:0] lane_addr;
	logic [1:0]                lane_we;
	logic                      lane_sel;
	logic [7:0]                lane_q [2];	// 0 even bytes, 1 odd bytes

	cart_header_regs header_i (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask, .cart_ready
	);

	mbc_bank_regs bank_i (
		.clk_sys, .reset, .cart_addr, .cart_wr, .cart_di, .mbc_kind, .rom_mask, .ram_mask,
		.rom_bank, .ram_bank, .ram_enable, .rtc_mode
	);

	mbc_rom_mapper rom_map_i (.cart_addr, .rom_bank, .mbc_kind, .rom_addr);

	// --------------------------------------------------
	// cart ram, two byte lanes
	// --------------------------------------------------
	cram_lane_ctrl #(.LANE_ADDR_BITS(LANE_ADDR_BITS)) lane_ctrl_i (
		.cart_addr, .cart_wr, .ram_bank, .mbc_kind, .lane_addr, .lane_we, .lane_sel
	);

	for (genvar i = 0; i < 2; i++) begin : g_lane
		cram_lane #(.LANE_ADDR_BITS(LANE_ADDR_BITS)) lane_i (
			.clk_sys,
			.addr  (lane_addr),
			.we    (lane_we[i]),
			.wdata (cart_di),
			.q     (lane_q[i])
		);
	end

	cram_read_mux rd_mux_i (
		.clk_sys, .cart_addr, .lane_sel,
		.lane_q_lo (lane_q[0]),
		.lane_q_hi (lane_q[1]),
		.rom_rdata, .ram_enable, .rtc_mode, .mbc_kind, .cart_ready, .cart_do
	);

endmodule

// File: mbc_bank_regs.sv
`timescale 1ns/100ps

module mbc_bank_regs import gb_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cart_addr_t cart_addr,
	input  logic       cart_wr,		// one-cycle cpu write strobe
	input  logic [7:0] cart_di,
	input  logic [2:0] mbc_kind,
	input  logic [8:0] rom_mask,
	input  logic [3:0] ram_mask,
	output logic [8:0] rom_bank,	// effective, mode and mask applied
	output logic [3:0] ram_bank,
	output logic       ram_enable,
	output logic       rtc_mode		// mbc3 maps the clock instead of ram
);

	logic [8:0] rom_bank_reg;
	logic [3:0] ram_bank_reg;
	logic       mbc1_mode;	// 1 gives the ram bank bits to the ram
	logic [8:0] rom_eff;
	logic [3:0] ram_eff;

	// --------------------------------------------------
	// cpu register writes below 0x8000
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			ram_enable   <= 1'b0;
			rtc_mode     <= 1'b0;
		end else if (cart_wr) begin
			case (cart_addr.ctl.sel)
				SEL_RAM_EN:
					ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);
				SEL_ROM_BANK: begin
					if (mbc_kind == MBC_5) begin
						if (cart_addr.ctl.sub[12])
							rom_bank_reg[8] <= cart_di[0];	// 0x3000-0x3fff
						else
							rom_bank_reg[7:0] <= cart_di;	// 0x2000-0x2fff
					end else if (cart_di[6:0] == 7'd0)
						rom_bank_reg <= 9'd1;	// bank 0 is never switched in
					else
						rom_bank_reg <= {2'b00, cart_di[6:0]};
				end
				SEL_RAM_BANK: begin
					if (mbc_kind == MBC_3) begin
						rtc_mode <= cart_di[3];	// 0x08-0x0c pick a clock register
						if (!cart_di[3])
							ram_bank_reg <= {2'b00, cart_di[1:0]};
					end else if (mbc_kind == MBC_5)
						ram_bank_reg <= cart_di[3:0];
					else
						ram_bank_reg <= {2'b00, cart_di[1:0]};
				end
				SEL_MODE:
					if (mbc_kind == MBC_1)
						mbc1_mode <= cart_di[0];
				default: ;	// ram window writes go to the lanes
			endcase
		end
	end

	// mbc1 mode 0 lends the two ram bank bits to rom bank 6:5
	always_comb begin
		rom_eff = {2'b00, rom_bank_reg[6:0]};	// mbc2 and mbc3 see 7 bits
		ram_eff = ram_bank_reg;
		case (mbc_kind)
			MBC_1: begin
				rom_eff = {2'b00, (mbc1_mode ? 2'b00 : ram_bank_reg[1:0]), rom_bank_reg[4:0]};
				ram_eff = mbc1_mode ? ram_bank_reg : 4'd0;
			end
			MBC_5: rom_eff = rom_bank_reg;
			default: ;
		endcase
	end

	assign rom_bank = rom_eff & rom_mask;	// mirror banks past the rom size
	assign ram_bank = ram_eff & ram_mask;

endmodule

// File: mbc_rom_mapper.sv
`timescale 1ns/100ps

module mbc_rom_mapper import gb_cart_pkg::*; (
	input  cart_addr_t  cart_addr,
	input  logic [8:0]  rom_bank,	// effective bank from the registers
	input  logic [2:0]  mbc_kind,
	output logic [22:0] rom_addr	// 16-bit word address into the rom image
);

	logic [8:0] bank;

	// --------------------------------------------------
	// bank for the current cpu address
	// --------------------------------------------------
	always_comb begin
		if (mbc_kind == MBC_NONE)
			bank = {8'd0, cart_addr.rom.region[0]};	// plain 32k, linear
		else if (cart_addr.rom.region == 2'd1) begin
			if (mbc_kind == MBC_5)
				bank = rom_bank;	// up to 512 banks
			else
				bank = {2'b00, rom_bank[6:0]};	// mbc1-3 reach 128 banks
		end else
			bank = 9'd0;	// fixed bank 0, also outside the rom space
	end

	// word address, byte lane picked later by offset bit 0
	assign rom_addr = {1'b0, bank, cart_addr.rom.offset[13:1]};

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_gb_cart -f tb.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

// File: tb.f
gb_cart_pkg.sv
cart_header_regs.sv
mbc_bank_regs.sv
mbc_rom_mapper.sv
cram_lane_ctrl.sv
cram_lane.sv
cram_read_mux.sv
gb_cart_top.sv
gb_cart_props.sv
tb_gb_cart.sv

// File: tb_gb_cart.sv
`timescale 1ns/100ps

module tb_gb_cart import gb_cart_pkg::*; ();

	localparam int RST_CYC = 4;		// reset pulse plus release
	localparam int DL_CYC  = 42;	// 40 header words plus framing
	localparam int N_ROM   = 16;
	localparam int N_BANK  = 24;
	localparam int N_RAM   = 40;
	// tests 1 to 5 in order, then the closing reads
	localparam int SEQ_CYCLES = (RST_CYC + 2 + DL_CYC + N_ROM) + (N_BANK * 4 + 8 * 4)
		+ (RST_CYC + 2 * DL_CYC + 2 * N_BANK * 4) + (RST_CYC + DL_CYC + 5 + N_RAM * 5)
		+ (2 * (RST_CYC + DL_CYC + 1) + 8 * 2 + 8 * 6) + 3;
	localparam int MAX_CYCLES = 2 * SEQ_CYCLES;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	cart_addr_t  cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [15:0] rom_rdata;
	logic [22:0] rom_addr;
	logic [7:0]  cart_do;

	// reference copy of header, mapper registers and cart ram
	logic [2:0]  m_kind;
	logic [8:0]  m_rom_mask;
	logic [3:0]  m_ram_mask;
	logic        m_ready;
	logic [8:0]  m_rom_bank;
	logic [3:0]  m_ram_bank;
	logic        m_mode;
	logic        m_ram_en;
	logic        m_rtc;
	logic [7:0]  ref_ram [131072];
	logic        chk_en;	// set by the stimulus on read cycles
	logic [30:0] expect_v;
	int          n_checks = 0;
	int          n_errors = 0;
	int          cycle_cnt = 0;

	always #2 clk_sys = ~clk_sys;

	gb_cart_top #(.LANE_ADDR_BITS(16)) dut_i (.*);

	// rom model, word is a hash of the whole word address
	function automatic logic [15:0] rom_word(input logic [22:0] a);
		return a[15:0] ^ {a[22:16], a[8:0]} ^ 16'hC3A5;
	endfunction

	assign rom_rdata = rom_word(rom_addr);

	function automatic logic [16:0] ram_addr(input logic [15:0] a);
		logic [3:0] b;
		b = (m_kind == MBC_1 && !m_mode) ? 4'd0 : m_ram_bank & m_ram_mask;
		if (m_kind == MBC_NONE || m_kind == MBC_2)
			b = 4'd0;	// no ram banking on these
		return {b, a[12:0]};
	endfunction

	// expected {rom_addr, cart_do} for cpu address a
	function automatic logic [30:0] ref_model(input logic [15:0] a);
		logic [8:0]  rb;
		logic [8:0]  bank;
		logic [22:0] ra;
		logic [15:0] w;
		logic [7:0]  rd;
		rb = (m_kind == MBC_5) ? m_rom_bank : {2'b00, m_rom_bank[6:0]};
		if (m_kind == MBC_1)
			rb = {2'b00, (m_mode ? 2'b00 : m_ram_bank[1:0]), m_rom_bank[4:0]};	// mode 0 lends bits 6:5
		if (m_kind == MBC_NONE)
			bank = {8'd0, a[14]};	// linear 32k
		else if (a[15:14] == 2'b01)
			bank = rb & m_rom_mask;
		else
			bank = 9'd0;
		ra = {1'b0, bank, a[13:1]};
		w = rom_word(ra);
		rd = ref_ram[ram_addr(a)];
		if (!m_ready)
			return {ra, 8'h00};
		else if (a[15:13] != SEL_CRAM)
			return {ra, (a[0] ? w[15:8] : w[7:0])};
		else if (!m_ram_en)
			return {ra, 8'hFF};
		else if (m_kind == MBC_2 && a[12:9] == 4'd0)
			return {ra, 4'hF, rd[3:0]};	// mbc2 nibble ram
		else if (m_rtc)
			return {ra, 8'h00};
		return {ra, rd};
	endfunction

	// --------------------------------------------------
	// compare, sampled between the edges
	// --------------------------------------------------
	always @(posedge clk_sys) begin
		#1;
		if (chk_en) begin
			expect_v = ref_model(cart_addr);
			n_checks++;
			if (rom_addr !== expect_v[30:8]) begin
				n_errors++;
				$display("CHECK FAILED %0t: rom_addr %h, expected %h at cpu address %h",
					$time, rom_addr, expect_v[30:8], cart_addr);
			end
			if (cart_do !== expect_v[7:0]) begin
				n_errors++;
				$display("CHECK FAILED %0t: cart_do %h, expected %h at cpu address %h",
					$time, cart_do, expect_v[7:0], cart_addr);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic do_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		chk_en = 1'b0;
		cart_wr = 1'b0;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
		m_kind = MBC_NONE;	// ram contents survive reset
		m_ready = 1'b0;
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		{m_mode, m_ram_en, m_rtc} = 3'b000;
	endtask

	// image words 0x100-0x14f, header bytes at their offsets
	task automatic download(input logic [7:0] ctype, input logic [7:0] rsize,
		input logic [7:0] asize);
		logic [31:0] rv;
		@(negedge clk_sys);
		chk_en = 1'b0;
		dl_active = 1'b1;
		for (int a = 'h100; a < 'h150; a += 2) begin
			@(negedge clk_sys);
			rv = $urandom();
			dl_wr = 1'b1;
			dl_addr = a[24:0];
			if (dl_addr == HDR_TYPE_OFS)
				dl_data = {ctype, rv[7:0]};
			else if (dl_addr == HDR_SIZE_OFS)
				dl_data = {asize, rsize};
			else if (dl_addr == HDR_CGB_OFS)
				dl_data = {8'h80, rv[7:0]};	// cgb compatible flag
			else
				dl_data = rv[15:0];
		end
		@(negedge clk_sys);
		dl_wr = 1'b0;
		dl_active = 1'b0;
		m_kind = (ctype inside {[8'h01:8'h03]}) ? MBC_1 :
			(ctype inside {[8'h05:8'h06]}) ? MBC_2 :
			(ctype inside {[8'h0F:8'h13]}) ? MBC_3 :
			(ctype inside {[8'h19:8'h1E]}) ? MBC_5 : MBC_NONE;
		m_rom_mask = (rsize <= 8'd8) ? 9'((10'd2 << rsize[3:0]) - 10'd1) : 9'h07F;
		m_ram_mask = (asize <= 8'd2) ? 4'h0 : (asize == 8'd3) ? 4'h3 : 4'hF;
		m_ready = 1'b1;
	endtask

	task automatic cpu_read(input logic [15:0] a);
		@(negedge clk_sys);
		cart_addr = a;
		cart_wr = 1'b0;
		cart_rd = 1'b1;
		chk_en = 1'b1;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cart_addr = a;
		cart_di = d;
		cart_wr = 1'b1;	// one-cycle strobe
		cart_rd = 1'b0;
		chk_en = 1'b0;
		case (a[15:13])
			SEL_RAM_EN:
				m_ram_en = (d[3:0] == RAM_ENABLE_KEY);
			SEL_ROM_BANK:
				if (m_kind != MBC_5)
					m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
				else if (a[12])
					m_rom_bank[8] = d[0];
				else
					m_rom_bank[7:0] = d;
			SEL_RAM_BANK:
				if (m_kind == MBC_3) begin
					m_rtc = d[3];
					if (!d[3])
						m_ram_bank = {2'b00, d[1:0]};
				end else
					m_ram_bank = (m_kind == MBC_5) ? d[3:0] : {2'b00, d[1:0]};
			SEL_MODE:
				if (m_kind == MBC_1)
					m_mode = d[0];
			SEL_CRAM:
				ref_ram[ram_addr(a)] = d;	// written even while disabled
			default: ;
		endcase
	endtask

	initial begin
		logic [31:0] rv;
		logic [16:0] saved [$];	// {bank, offset} of written ram bytes
		logic [16:0] ent;
		int          idx;
		rv = $urandom(32'h2e963eaf);	// one seed for the run
		reset = 1'b1;
		{dl_active, dl_wr, cart_rd, cart_wr, chk_en} = '0;
		dl_addr = '0;
		dl_data = '0;
		cart_addr = '0;
		cart_di = '0;

		// --------------------------------------------------
		// no image, then mbc1 with 64 banks and 32k ram
		do_reset();
		cpu_read(16'h0123);
		cpu_read(16'hA000);
		download(8'h01, 8'h05, 8'h03);
		repeat (N_ROM) begin
			rv = $urandom();
			cpu_read({2'b00, rv[13:0]});
		end
		repeat (N_BANK) begin
			rv = $urandom();
			cpu_write({3'b001, rv[12:0]}, rv[20] ? 8'h00 : rv[31:24]);	// 0 reads as 1
			repeat (3) begin
				rv = $urandom();
				cpu_read({2'b01, rv[13:0]});
			end
		end
		for (int i = 0; i < 8; i++) begin
			rv = $urandom();
			cpu_write({3'b010, rv[12:0]}, rv[20:13]);
			cpu_write({3'b011, rv[12:0]}, {7'd0, i[0]});	// flip the mode bit
			cpu_read({2'b01, rv[13:0]});
			cpu_read({3'b101, rv[12:0]});
		end

		// mbc5, 512 banks, then 128 banks so bits 8:7 mask off
		do_reset();
		download(8'h19, 8'h08, 8'h00);
		for (int i = 0; i < 2 * N_BANK; i++) begin
			rv = $urandom();
			if (i == N_BANK)
				download(8'h19, 8'h06, 8'h00);
			cpu_write({4'b0010, rv[11:0]}, (i % 5 == 0) ? 8'h00 : rv[19:12]);
			cpu_write({4'b0011, rv[11:0]}, (i % 5 == 0) ? 8'h00 : {7'd0, rv[20]});
			cpu_read({2'b01, rv[13:0]});
			cpu_read({2'b01, rv[27:14]});
		end

		// --------------------------------------------------
		// cart ram over sixteen banks
		do_reset();
		download(8'h1B, 8'h04, 8'h04);
		cpu_read(16'hA000);
		cpu_read(16'hBFFF);
		cpu_write(16'h0000, 8'h0A);
		repeat (N_RAM) begin
			rv = $urandom();
			cpu_write(16'h4000, {4'd0, rv[3:0]});
			cpu_write({3'b101, rv[16:4]}, rv[24:17]);
			cpu_read({3'b101, rv[16:4]});
			saved.push_back({rv[3:0], rv[16:4]});
		end
		repeat (N_RAM) begin
			rv = $urandom();
			idx = int'(rv[15:0]) % saved.size();
			ent = saved[idx];
			cpu_write(16'h4000, {4'd0, ent[16:13]});
			cpu_read({3'b101, ent[12:0]});
		end
		cpu_write(16'h0000, 8'h00);
		cpu_read(16'hA000);

		// mbc2 nibble ram, then mbc3 with clock select
		do_reset();
		download(8'h06, 8'h02, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		repeat (8) begin
			rv = $urandom();
			cpu_write({7'b1010000, rv[8:0]}, rv[16:9]);
			cpu_read({7'b1010000, rv[8:0]});
		end
		do_reset();
		download(8'h13, 8'h03, 8'h03);
		cpu_write(16'h0000, 8'h0A);
		repeat (8) begin
			rv = $urandom();
			cpu_write(16'h4000, {6'd0, rv[1:0]});
			cpu_write({3'b101, rv[14:2]}, rv[22:15]);
			cpu_write(16'h4000, 8'h08);	// seconds register
			cpu_read({3'b101, rv[14:2]});
			cpu_write(16'h4000, {6'd0, rv[1:0]});
			cpu_read({3'b101, rv[14:2]});
		end

		cpu_read(16'h0000);
		@(negedge clk_sys);
		chk_en = 1'b0;
		@(negedge clk_sys);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
